// File: design/rv_core_params.svh
//##############################
// Core widths and constants
//##############################

`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Datapath and PC width
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Byte address into instruction memory, 64 words
`define IMEM_ADDR_W 8

`define PC_STEP     4
`define RESET_PC    0

`endif

// File: design/rv_core_pkg.sv
//##############################
// Opcode, ALU operation and
// decode control types
//##############################

`default_nettype none

package rv_core_pkg;

    // Only the opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // R-type
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,  // Zero code, keeps the NOP control all zero
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // LUI
    } alu_op_e;

    // All zero acts as a NOP
    typedef struct packed {
        logic    reg_write;
        logic    use_imm;
        alu_op_e alu_op;
    } id_ctrl_t;

endpackage

`default_nettype wire

// File: design/rv_fetch_stage.sv
//##############################
// Fetch stage: PC, instruction
// memory with load port, IF/ID
//##############################

`default_nettype none
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_fetch_stage (
    input  wire                      clk,
    input  wire                      i_arst_n,
    input  wire                      i_en,
    input  wire                      i_imem_wen,
    input  wire [`IMEM_ADDR_W-1:0]   i_imem_waddr,
    input  wire [`XLEN-1:0]          i_imem_data,
    output logic [`XLEN-1:0]         o_pc,
    output logic [`XLEN-1:0]         o_instr
);

    // Word index drops the two byte-offset bits
    localparam int IMEM_IDX_W = `IMEM_ADDR_W - 2;
    localparam int IMEM_WORDS = 1 << IMEM_IDX_W;

    logic [`XLEN-1:0]      imem [0:IMEM_WORDS-1];
    logic [`XLEN-1:0]      imem_rdata;
    logic [IMEM_IDX_W-1:0] rd_idx;

    // Load port, whole words only
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr[`IMEM_ADDR_W-1:2]] <= i_imem_data;
        end
    end

    // PC wraps inside the memory
    assign rd_idx     = o_pc[`IMEM_ADDR_W-1:2];
    assign imem_rdata = imem[rd_idx];  // Combinational read

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= `XLEN'(`RESET_PC);
        end else if (i_en) begin
            o_pc <= o_pc + `XLEN'(`PC_STEP);
        end
    end

    // IF/ID register, zero is a NOP opcode
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_instr <= '0;
        end else if (i_en) begin
            o_instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_decode_stage.sv
//##############################
// Decode stage: register file,
// control decode, immediates,
// ID/EX register
//##############################

`default_nettype none
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_decode_stage (
    input  wire                      clk,
    input  wire                      i_arst_n,
    input  wire                      i_en,
    input  wire [`XLEN-1:0]          i_instr,
    input  wire                      i_wb_en,
    input  wire [`REG_ADDR_W-1:0]    i_wb_rd,
    input  wire [`XLEN-1:0]          i_wb_data,
    output rv_core_pkg::id_ctrl_t    o_ctrl,
    output logic [`XLEN-1:0]         o_rs1_data,
    output logic [`XLEN-1:0]         o_rs2_data,
    output logic [`XLEN-1:0]         o_imm,
    output logic [`REG_ADDR_W-1:0]   o_rs1,
    output logic [`REG_ADDR_W-1:0]   o_rs2,
    output logic [`REG_ADDR_W-1:0]   o_rd
);

    import rv_core_pkg::*;

    logic [`XLEN-1:0]       regs [0:`NUM_REGS-1];
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    alu_op_e                f3_op;
    id_ctrl_t               ctrl;

    assign opcode = opcode_e'(i_instr[6:0]);
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    // Register file, x0 is never written
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_en && i_wb_en && (i_wb_rd != '0)) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Write-through so a same-cycle write is seen here
    assign rs1_data = (rs1 == '0) ? '0 :
                      (i_wb_en && (i_wb_rd == rs1)) ? i_wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (i_wb_en && (i_wb_rd == rs2)) ? i_wb_data : regs[rs2];

    // U-type for LUI, I-type otherwise
    assign imm = (opcode == OPC_LUI) ? {i_instr[31:12], 12'b0} :
                                       {{20{i_instr[31]}}, i_instr[31:20]};

    // funct3 to ALU op, bit 30 picks SUB and SRA
    always_comb begin
        case (funct3)
            3'd0:    f3_op = (i_instr[30] && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'd1:    f3_op = ALU_SLL;
            3'd2:    f3_op = ALU_SLT;
            3'd3:    f3_op = ALU_SLTU;
            3'd4:    f3_op = ALU_XOR;
            3'd5:    f3_op = i_instr[30] ? ALU_SRA : ALU_SRL;
            3'd6:    f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;  // Unknown opcode becomes a NOP
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = f3_op;
                ctrl.reg_write = (rd != '0);
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = f3_op;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = (rd != '0);
            end
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = (rd != '0);
            end
            default: ctrl = '0;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ctrl <= '0;
        end else if (i_en) begin
            o_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_rs1_data <= rs1_data;
            o_rs2_data <= rs2_data;
            o_imm      <= imm;
            o_rs1      <= rs1;
            o_rs2      <= rs2;
            o_rd       <= rd;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_execute_stage.sv
//##############################
// Execute stage: forwarding,
// ALU and EX/WB register
//##############################

`default_nettype none
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_execute_stage (
    input  wire                      clk,
    input  wire                      i_arst_n,
    input  wire                      i_en,
    input  wire rv_core_pkg::id_ctrl_t i_ctrl,
    input  wire [`XLEN-1:0]          i_rs1_data,
    input  wire [`XLEN-1:0]          i_rs2_data,
    input  wire [`XLEN-1:0]          i_imm,
    input  wire [`REG_ADDR_W-1:0]    i_rs1,
    input  wire [`REG_ADDR_W-1:0]    i_rs2,
    input  wire [`REG_ADDR_W-1:0]    i_rd,
    output logic                     o_wb_en,
    output logic [`REG_ADDR_W-1:0]   o_wb_rd,
    output logic [`XLEN-1:0]         o_wb_data
);

    import rv_core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    // Forward the previous result held in EX/WB
    assign op_a  = (o_wb_en && (o_wb_rd == i_rs1)) ? o_wb_data : i_rs1_data;
    assign fwd_b = (o_wb_en && (o_wb_rd == i_rs2)) ? o_wb_data : i_rs2_data;
    assign op_b  = i_ctrl.use_imm ? i_imm : fwd_b;

    assign shamt = op_b[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = `XLEN'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;  // LUI
            default:    alu_result = '0;
        endcase
    end

    // EX/WB register
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_en <= 1'b0;
        end else if (i_en) begin
            o_wb_en <= i_ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_wb_rd   <= i_rd;
            o_wb_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_core.sv
//##############################
// Core top: fetch, decode and
// execute stages
//##############################

`default_nettype none
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_core (
    input  wire                      clk,
    input  wire                      i_arst_n,
    input  wire                      i_en,
    input  wire                      i_imem_wen,
    input  wire [`IMEM_ADDR_W-1:0]   i_imem_waddr,
    input  wire [`XLEN-1:0]          i_imem_data,
    output logic [`XLEN-1:0]         o_pc,
    output logic                     o_wb_en,
    output logic [`REG_ADDR_W-1:0]   o_wb_rd,
    output logic [`XLEN-1:0]         o_wb_data
);

    import rv_core_pkg::*;

    logic [`XLEN-1:0]       if_id_instr;

    // ID/EX
    id_ctrl_t               id_ex_ctrl;
    logic [`XLEN-1:0]       id_ex_rs1_data;
    logic [`XLEN-1:0]       id_ex_rs2_data;
    logic [`XLEN-1:0]       id_ex_imm;
    logic [`REG_ADDR_W-1:0] id_ex_rs1;
    logic [`REG_ADDR_W-1:0] id_ex_rs2;
    logic [`REG_ADDR_W-1:0] id_ex_rd;

    rv_fetch_stage u_fetch (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .o_pc         (o_pc),
        .o_instr      (if_id_instr)
    );

    // Write-back trace also feeds the register file
    rv_decode_stage u_decode (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_en       (i_en),
        .i_instr    (if_id_instr),
        .i_wb_en    (o_wb_en),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data),
        .o_ctrl     (id_ex_ctrl),
        .o_rs1_data (id_ex_rs1_data),
        .o_rs2_data (id_ex_rs2_data),
        .o_imm      (id_ex_imm),
        .o_rs1      (id_ex_rs1),
        .o_rs2      (id_ex_rs2),
        .o_rd       (id_ex_rd)
    );

    rv_execute_stage u_execute (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_en       (i_en),
        .i_ctrl     (id_ex_ctrl),
        .i_rs1_data (id_ex_rs1_data),
        .i_rs2_data (id_ex_rs2_data),
        .i_imm      (id_ex_imm),
        .i_rs1      (id_ex_rs1),
        .i_rs2      (id_ex_rs2),
        .i_rd       (id_ex_rd),
        .o_wb_en    (o_wb_en),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

endmodule

`default_nettype wire

// File: tb/tb_rv_ref_model.svh
//##############################
// Reference model, LFSR and
// instruction builders
//##############################

`ifndef TB_RV_REF_MODEL_SVH
`define TB_RV_REF_MODEL_SVH

logic [31:0] model_regs [0:31];
logic [15:0] lfsr_state = 16'd31991;

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

function automatic logic [31:0] rtype_word(input logic sub, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
endfunction

// Executes one instruction on model_regs, returns 1 when rd is written
function automatic logic ref_exec(input logic [31:0] instr, output logic [4:0] rd,
                                  output logic [31:0] value);
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  f3;
    logic        is_r;
    logic        valid;
    rd    = instr[11:7];
    f3    = instr[14:12];
    is_r  = (instr[6:0] == OPC_OP);
    valid = is_r || (instr[6:0] == OPC_OP_IMM);
    a     = model_regs[instr[19:15]];
    b     = is_r ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    case (f3)
        3'd0:    value = (is_r && instr[30]) ? a - b : a + b;
        3'd1:    value = a << b[4:0];
        3'd2:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    value = (a < b) ? 32'd1 : 32'd0;
        3'd4:    value = a ^ b;
        3'd5:    value = instr[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    value = a | b;
        default: value = a & b;
    endcase
    if (instr[6:0] == OPC_LUI) begin
        valid = 1'b1;
        value = {instr[31:12], 12'b0};
    end
    if (valid && rd != 5'd0) begin
        model_regs[rd] = value;
        return 1'b1;
    end
    return 1'b0;
endfunction

`endif

// File: tb/tb_rv_core.sv
//##############################
// Testbench for rv_core
//##############################

`default_nettype none
`timescale 1ns/1ps

`include "rv_core_params.svh"

module tb_rv_core;

    import rv_core_pkg::*;

    `include "tb_rv_ref_model.svh"

    localparam int IMEM_WORDS     = 64;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_DIRECTED   = 33;
    localparam int NUM_RANDOM     = 48;
    localparam int LOAD_CYCLES    = 2 * (RESET_CYCLES + IMEM_WORDS + 9);
    localparam int TIMEOUT_CYCLES = LOAD_CYCLES + 2 * (NUM_DIRECTED + NUM_RANDOM) + 50;

    logic                   clk;
    logic                   i_arst_n;
    logic                   i_en;
    logic                   i_imem_wen;
    logic [`IMEM_ADDR_W-1:0] i_imem_waddr;
    logic [`XLEN-1:0]       i_imem_data;
    logic [`XLEN-1:0]       o_pc;
    logic                   o_wb_en;
    logic [`REG_ADDR_W-1:0] o_wb_rd;
    logic [`XLEN-1:0]       o_wb_data;

    logic [31:0] prog [0:IMEM_WORDS-1];
    logic [36:0] exp_q [$];  // {rd, value}
    logic [31:0] pc_model;
    int          value_errors;
    int          other_errors;
    int          cycles;

    rv_core uut (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .o_pc         (o_pc),
        .o_wb_en      (o_wb_en),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Old outputs are seen at the edge, one pop per enabled edge
    always @(posedge clk) begin : compare_wb
        logic [36:0] exp_wb;
        if (!i_arst_n) begin
            pc_model = `XLEN'(`RESET_PC);
        end else begin
            check_value("o_pc", o_pc, pc_model);
            if (i_en) begin
                pc_model = pc_model + `XLEN'(`PC_STEP);
            end
            if (i_en && o_wb_en) begin
                if (o_wb_rd == '0) begin
                    other_errors++;
                    $display("ERROR: write-back to x0 seen at %0t", $time);
                end
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("ERROR: write-back with no instruction left to retire");
                end else begin
                    exp_wb = exp_q.pop_front();
                    check_value("o_wb_rd", 32'(o_wb_rd), 32'(exp_wb[36:32]));
                    check_value("o_wb_data", o_wb_data, exp_wb[31:0]);
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic apply_reset();
        i_arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        i_arst_n = 1'b1;
    endtask

    task automatic load_program();
        i_imem_wen = 1'b1;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            i_imem_waddr = 8'(w * 4);
            i_imem_data  = prog[w];
            @(posedge clk);
            #10;
        end
        i_imem_wen = 1'b0;
    endtask

    task automatic directed_program();
        for (int w = 0; w < IMEM_WORDS; w++) begin
            prog[w] = '0;
        end
        // Independent block, every operation once
        prog[0]  = lui_word(20'hF0F0F, 5'd1);
        prog[1]  = itype_word(12'hFDB, 3'd0, 5'd2, 5'd0);  // -37
        prog[2]  = itype_word(12'h123, 3'd0, 5'd3, 5'd0);
        prog[3]  = itype_word(12'h005, 3'd2, 5'd4, 5'd1);
        prog[4]  = itype_word(12'h064, 3'd3, 5'd5, 5'd2);
        prog[5]  = itype_word(12'hFFF, 3'd4, 5'd6, 5'd3);
        prog[6]  = itype_word(12'h0FF, 3'd6, 5'd7, 5'd1);
        prog[7]  = itype_word(12'h7F0, 3'd7, 5'd8, 5'd2);
        prog[8]  = itype_word(12'h007, 3'd1, 5'd9, 5'd3);
        prog[9]  = itype_word(12'h004, 3'd5, 5'd10, 5'd1);
        prog[10] = itype_word(12'h403, 3'd5, 5'd11, 5'd2);  // SRAI
        prog[11] = rtype_word(1'b0, 3'd0, 5'd12, 5'd1, 5'd3);
        prog[12] = rtype_word(1'b1, 3'd0, 5'd13, 5'd3, 5'd2);
        prog[13] = rtype_word(1'b0, 3'd1, 5'd14, 5'd3, 5'd2);
        prog[14] = rtype_word(1'b0, 3'd2, 5'd15, 5'd2, 5'd3);
        prog[15] = rtype_word(1'b0, 3'd3, 5'd16, 5'd2, 5'd3);
        prog[16] = rtype_word(1'b0, 3'd4, 5'd17, 5'd1, 5'd2);
        prog[17] = rtype_word(1'b0, 3'd5, 5'd18, 5'd1, 5'd3);
        prog[18] = rtype_word(1'b1, 3'd5, 5'd19, 5'd1, 5'd3);
        prog[19] = rtype_word(1'b0, 3'd6, 5'd20, 5'd2, 5'd3);
        prog[20] = rtype_word(1'b0, 3'd7, 5'd21, 5'd1, 5'd2);
        prog[21] = itype_word(12'h005, 3'd0, 5'd0, 5'd0);   // x0 target
        // Each reads the result just before
        prog[22] = itype_word(12'h005, 3'd0, 5'd22, 5'd0);
        prog[23] = rtype_word(1'b0, 3'd0, 5'd22, 5'd22, 5'd22);
        prog[24] = rtype_word(1'b1, 3'd0, 5'd23, 5'd22, 5'd1);
        prog[25] = rtype_word(1'b0, 3'd4, 5'd24, 5'd23, 5'd22);
        prog[26] = rtype_word(1'b1, 3'd5, 5'd25, 5'd24, 5'd22);
        prog[27] = itype_word(12'h003, 3'd1, 5'd26, 5'd25);
        // Sources two slots back
        prog[28] = itype_word(12'h04D, 3'd0, 5'd27, 5'd0);
        prog[29] = itype_word(12'h00B, 3'd0, 5'd28, 5'd0);
        prog[30] = rtype_word(1'b0, 3'd0, 5'd29, 5'd27, 5'd26);
        prog[31] = rtype_word(1'b1, 3'd0, 5'd30, 5'd28, 5'd27);
        prog[32] = rtype_word(1'b0, 3'd6, 5'd31, 5'd29, 5'd28);
    endtask

    task automatic random_program();
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        sub;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            prog[w] = '0;
        end
        for (int w = 0; w < NUM_RANDOM; w++) begin
            kind = 2'(rand_bits(2));
            rd   = 5'(rand_bits(3));  // Few registers, many dependencies
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            if (w % 8 == 7) begin
                rd = 5'd0;
            end
            if (kind == 2'd0) begin
                sub     = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rand_bits(1)) : 1'b0;
                prog[w] = rtype_word(sub, f3, rd, rs1, rs2);
            end else if (kind == 2'd3) begin
                prog[w] = lui_word(20'(rand_bits(20)), rd);
            end else begin
                if (f3 == 3'd1) begin
                    imm = {7'b0, 5'(rand_bits(5))};
                end else if (f3 == 3'd5) begin
                    imm = {1'b0, 1'(rand_bits(1)), 5'b0, 5'(rand_bits(5))};
                end else begin
                    imm = 12'(rand_bits(12));
                end
                prog[w] = itype_word(imm, f3, rd, rs1);
            end
        end
    endtask

    task automatic build_expected(input int n);
        logic [4:0]  rd;
        logic [31:0] value;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int w = 0; w < n; w++) begin
            if (ref_exec(prog[w], rd, value)) begin
                exp_q.push_back({rd, value});
            end
        end
    endtask

    // Runs a number of enabled edges, stalls take at most n_edges cycles in all
    task automatic step_enabled(input int n_edges, input logic stalls);
        int enabled;
        int budget;
        int len;
        enabled = 0;
        budget  = n_edges;
        i_en    = 1'b1;
        while (enabled < n_edges) begin
            @(posedge clk);
            enabled++;
            #10;
            if (stalls && budget > 0 && rand_bits(2) == 0) begin
                len = 1 + int'(rand_bits(2));
                if (len > budget) begin
                    len = budget;
                end
                budget -= len;
                i_en = 1'b0;
                repeat (len) begin
                    @(posedge clk);
                    #10;
                end
                i_en = 1'b1;
            end
        end
        i_en = 1'b0;
    endtask

    task automatic run_phase(input int n, input logic stalls);
        apply_reset();
        check_value("o_wb_en", 32'(o_wb_en), 32'd0);
        check_value("o_pc", o_pc, `XLEN'(`RESET_PC));
        load_program();
        repeat (4) @(posedge clk);  // PC must hold while disabled
        #10;
        build_expected(n);
        step_enabled(n + 4, stalls);
        repeat (5) @(posedge clk);
        #10;
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("ERROR: %0d expected write-backs never appeared", exp_q.size());
        end
        exp_q.delete();
    endtask

    initial begin : stimulus
        i_arst_n     = 1'b0;
        i_en         = 1'b0;
        i_imem_wen   = 1'b0;
        i_imem_waddr = '0;
        i_imem_data  = '0;
        value_errors = 0;
        other_errors = 0;

        directed_program();
        run_phase(NUM_DIRECTED, 1'b0);
        random_program();
        run_phase(NUM_RANDOM, 1'b1);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+design
+incdir+tb
design/rv_core_pkg.sv
design/rv_fetch_stage.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_core.sv
tb/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
